//--- list.f
logic/periph_regs_pkg.sv
logic/spi_pkg.sv
logic/periph_iobuf.sv
logic/wb_reg_bank.sv
logic/spi_clk_timer.sv
logic/spi_shift_reg.sv
logic/spi_sequencer.sv
logic/periph_top.sv
dv/periph_checker.sv
dv/periph_properties.sv
dv/tb_periph_top.sv

//--- run.sh
#!/bin/sh
# Build and run the peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module tb_periph_top \
  -o sim_periph

./obj_dir/sim_periph > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

//--- dv/tb_periph_top.sv
/* Peripheral subsystem testbench */

module tb_periph_top;

  timeunit 1ns;
  timeprecision 100ps;

  import periph_regs_pkg::*;

  localparam int GPIO_WIDTH   = 8;
  localparam int NUM_CS       = 2;
  localparam int NAME_W       = 8*24;
  localparam int ACK_TIMEOUT  = 20;
  localparam int BUSY_TIMEOUT = 200;

  localparam logic [1:0] K_BUS  = 2'd0;
  localparam logic [1:0] K_PAD  = 2'd1;
  localparam logic [1:0] K_PINS = 2'd2;
  localparam logic [1:0] K_SPI  = 2'd3;

  typedef enum {OP_WRITE, OP_READ, OP_DRIVE, OP_PAD, OP_PINS, OP_SPI, OP_SPI_BUSY} op_e;

  // arg holds the divider in bits 7:0 and the chip selects above it
  typedef struct {
    string       name;
    op_e         op;
    wb_addr_t    adr;
    wb_data_t    wdata;
    logic [15:0] arg;
    wb_data_t    exp;
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  wb_addr_t              wb_adr;
  wb_data_t              wb_wdat;
  wb_data_t              wb_rdat;
  logic                  wb_ack;
  wire  [GPIO_WIDTH-1:0] gpio_pad;
  logic                  sclk;
  logic                  mosi;
  logic [NUM_CS-1:0]     cs_n;

  logic [GPIO_WIDTH-1:0] pad_val;
  logic [GPIO_WIDTH-1:0] pad_rel;
  logic                  chk_stb;
  logic [1:0]            chk_kind;
  logic [NAME_W-1:0]     chk_name;
  logic [31:0]           chk_exp;
  logic                  cnt_clr;
  logic [NUM_CS-1:0]     cs_exp;
  logic                  fin;
  int                    timeouts;
  int                    fail_cnt;
  entry_t                tbl[$];

  // Pads that the DUT drives are released by the bench
  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad_drv
    assign gpio_pad[i] = pad_rel[i] ? 1'bz : pad_val[i];
  end

  periph_top #(
    .GPIO_WIDTH (GPIO_WIDTH),
    .NUM_CS     (NUM_CS)
  ) UUT (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_wdat),
    .wb_dat_o   (wb_rdat),
    .wb_ack_o   (wb_ack),
    .gpio_io    (gpio_pad),
    .spi_sclk_o (sclk),
    .spi_mosi_o (mosi),
    .spi_miso_i (mosi),
    .spi_cs_n_o (cs_n)
  );

  periph_checker #(
    .GPIO_WIDTH (GPIO_WIDTH),
    .NUM_CS     (NUM_CS),
    .NAME_W     (NAME_W)
  ) u_checker (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .chk_stb_i  (chk_stb),
    .chk_kind_i (chk_kind),
    .chk_name_i (chk_name),
    .chk_exp_i  (chk_exp),
    .clr_i      (cnt_clr),
    .cs_exp_i   (cs_exp),
    .fin_i      (fin),
    .timeouts_i (timeouts),
    .wb_dat_i   (wb_rdat),
    .wb_ack_i   (wb_ack),
    .busy_i     (UUT.spi_busy),
    .sclk_i     (sclk),
    .mosi_i     (mosi),
    .cs_n_i     (cs_n),
    .pad_i      (gpio_pad),
    .fail_cnt_o (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // **************************************************************************
  // Bus and check helpers

  function automatic logic [NAME_W-1:0] pack_name(input string s);
    logic [NAME_W-1:0] v;
    v = '0;
    for (int i = 0; i < s.len() && i < NAME_W/8; i++) begin
      v = {v[NAME_W-9:0], s[i]};
    end
    return v;
  endfunction

  task automatic bus_write(input wb_addr_t adr, input wb_data_t data);
    int n;
    n = 0;
    @(negedge clk);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_adr  = adr;
    wb_wdat = data;
    while (!wb_ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack) begin
      $display("Timeout: no ack for the write to address %0d", adr);
      timeouts++;
    end
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input wb_addr_t adr, output wb_data_t data);
    int n;
    n    = 0;
    data = '0;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    while (!wb_ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (wb_ack) begin
      data = wb_rdat;
    end else begin
      $display("Timeout: no ack for the read of address %0d", adr);
      timeouts++;
    end
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic check(input string name, input logic [1:0] kind, input wb_data_t exp);
    @(negedge clk);
    chk_name = pack_name(name);
    chk_kind = kind;
    chk_exp  = exp;
    chk_stb  = 1'b1;
    @(negedge clk);
    chk_stb  = 1'b0;
  endtask

  task automatic wait_idle(input string name);
    wb_data_t st;
    int       n;
    n  = 0;
    st = 32'h1;
    while (st[STATUS_BUSY_BIT] && n < BUSY_TIMEOUT) begin
      bus_read(REG_STATUS, st);
      n++;
    end
    if (st[STATUS_BUSY_BIT]) begin
      $display("Timeout: %s stayed busy for %0d status polls", name, n);
      timeouts++;
    end
  endtask

  task automatic run_spi(input entry_t e, input bit overlap);
    wb_data_t rd;
    bus_write(REG_SPI_DIV, wb_data_t'(e.arg[7:0]));
    bus_write(REG_SPI_CS, wb_data_t'(e.arg[8 +: NUM_CS]));
    @(negedge clk);
    cs_exp  = e.arg[8 +: NUM_CS];
    cnt_clr = 1'b1;
    @(negedge clk);
    cnt_clr = 1'b0;
    bus_write(REG_SPI_DATA, e.wdata);
    // The second word lands while the first transfer runs
    if (overlap) bus_write(REG_SPI_DATA, ~e.wdata & 32'hFF);
    wait_idle(e.name);
    check({e.name, "_edges"}, K_SPI, 32'd8);
    bus_read(REG_SPI_DATA, rd);
    check(e.name, K_BUS, e.exp);
  endtask

  // **************************************************************************
  // Stimulus table

  task automatic add(input string name, input op_e op, input wb_addr_t adr,
                     input wb_data_t wdata, input logic [15:0] arg, input wb_data_t exp);
    entry_t e;
    e.name  = name;
    e.op    = op;
    e.adr   = adr;
    e.wdata = wdata;
    e.arg   = arg;
    e.exp   = exp;
    tbl.push_back(e);
  endtask

  function automatic wb_data_t readback(input wb_addr_t a, input wb_data_t d);
    case (a)
      REG_GPIO_OUT, REG_GPIO_DIR: return d & 32'((64'd1 << GPIO_WIDTH) - 1);
      REG_SPI_DIV:                return d & 32'hFF;
      REG_SPI_CS:                 return d & 32'((64'd1 << NUM_CS) - 1);
      default:                    return RD_UNMAPPED;
    endcase
  endfunction

  task automatic build_table();
    wb_addr_t    ra[5];
    wb_data_t    rv[5];
    int          divs[3];
    logic [7:0]  b;
    logic [1:0]  cs;
    // MOSI and SCLK low, all chip selects high
    add("rst_pins", OP_PINS, 0, 0, 0, 32'({1'b0, 1'b0, {NUM_CS{1'b1}}}));
    add("rst_gpio_out", OP_READ, REG_GPIO_OUT, 0, 0, RST_GPIO_OUT);
    add("rst_gpio_dir", OP_READ, REG_GPIO_DIR, 0, 0, RST_GPIO_DIR);
    add("rst_gpio_in", OP_READ, REG_GPIO_IN, 0, 0, 0);
    add("rst_spi_div", OP_READ, REG_SPI_DIV, 0, 0, RST_SPI_DIV);
    add("rst_spi_cs", OP_READ, REG_SPI_CS, 0, 0, RST_SPI_CS);
    add("rst_spi_data", OP_READ, REG_SPI_DATA, 0, 0, RST_SPI_DATA);
    add("rst_status", OP_READ, REG_STATUS, 0, 0, 0);
    add("rst_unmapped", OP_READ, 3'd7, 0, 0, RD_UNMAPPED);
    ra = '{REG_GPIO_OUT, REG_GPIO_DIR, REG_SPI_DIV, REG_SPI_CS, 3'd7};
    rv = '{32'hFFFF_FF5A, 32'hFFFF_FF00, 32'hABCD_0107, 32'hFFFF_FFFE, 32'hFFFF_FFFF};
    for (int i = 0; i < 5; i++) begin
      add("", OP_WRITE, ra[i], rv[i], 0, 0);
      add($sformatf("rdback_a%0d", ra[i]), OP_READ, ra[i], 0, 0, readback(ra[i], rv[i]));
    end
    // Low nibble driven by the DUT, high nibble by the bench
    add("", OP_DRIVE, 0, 32'h3C, 16'h0F, 0);
    add("", OP_WRITE, REG_GPIO_OUT, 32'hA5, 0, 0);
    add("", OP_WRITE, REG_GPIO_DIR, 32'h0F, 0, 0);
    add("gpio_pads", OP_PAD, 0, 0, 0, (32'hA5 & 32'h0F) | (32'h3C & ~32'h0F));
    add("gpio_in", OP_READ, REG_GPIO_IN, 0, 0, (32'hA5 & 32'h0F) | (32'h3C & ~32'h0F));
    divs = '{0, 1, 3};
    for (int d = 0; d < 3; d++) begin
      for (int k = 0; k < 3; k++) begin
        b  = 8'($urandom());
        cs = (k % 2) ? 2'b10 : 2'b01;
        add($sformatf("spi_d%0d_%0d", divs[d], k), OP_SPI, REG_SPI_DATA,
            32'(b), {6'd0, cs, 8'(divs[d])}, 32'(b));
      end
    end
    b = 8'($urandom());
    add("spi_busy_wr", OP_SPI_BUSY, REG_SPI_DATA, 32'(b), {6'd0, 2'b11, 8'd1}, 32'(b));
  endtask

  task automatic run_entry(input entry_t e);
    wb_data_t rd;
    case (e.op)
      OP_WRITE: bus_write(e.adr, e.wdata);
      OP_READ: begin
        bus_read(e.adr, rd);
        check(e.name, K_BUS, e.exp);
      end
      OP_DRIVE: begin
        @(negedge clk);
        pad_val = e.wdata[GPIO_WIDTH-1:0];
        pad_rel = e.arg[GPIO_WIDTH-1:0];
      end
      OP_PAD:      check(e.name, K_PAD, e.exp);
      OP_PINS:     check(e.name, K_PINS, e.exp);
      OP_SPI:      run_spi(e, 1'b0);
      OP_SPI_BUSY: run_spi(e, 1'b1);
      default: ;
    endcase
  endtask

  initial begin
    void'($urandom(30839));
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdat  = '0;
    pad_val  = '0;
    pad_rel  = '0;
    chk_stb  = 1'b0;
    chk_kind = K_BUS;
    chk_name = '0;
    chk_exp  = '0;
    cnt_clr  = 1'b0;
    cs_exp   = '0;
    fin      = 1'b0;
    timeouts = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    build_table();
    foreach (tbl[i]) begin
      run_entry(tbl[i]);
    end
    @(negedge clk);
    fin = 1'b1;
    @(negedge clk);
    fin = 1'b0;
    @(negedge clk);
    if (fail_cnt == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- dv/periph_properties.sv
/* Bus and SPI protocol assertions */

module periph_properties #(
  parameter int NUM_CS = 2
) (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              wb_cyc_i,
  input logic              wb_stb_i,
  input logic              wb_ack_i,
  input logic              busy_i,
  input logic              sclk_i,
  input logic [NUM_CS-1:0] cs_n_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Ack answers a live request only
  ack_needs_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("ack without cyc and stb");

  // Ack is a single-cycle pulse
  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("ack held for two cycles");

  // An idle sequencer keeps the SPI lines quiet
  idle_lines_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_i |-> ((cs_n_i == '1) && !sclk_i))
    else $error("cs_n or sclk active while idle");

  // SCLK moves only inside a transfer
  sclk_only_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $changed(sclk_i) |-> $past(busy_i))
    else $error("sclk toggled while not busy");

endmodule

bind periph_top periph_properties #(
  .NUM_CS (NUM_CS)
) u_props (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_i (wb_ack_o),
  .busy_i   (spi_busy),
  .sclk_i   (spi_sclk_o),
  .cs_n_i   (spi_cs_n_o)
);

//--- dv/periph_checker.sv
/* Peripheral result checker */

module periph_checker #(
  parameter int GPIO_WIDTH = 8,
  parameter int NUM_CS     = 2,
  parameter int NAME_W     = 8*24
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  chk_stb_i,
  input  logic [1:0]            chk_kind_i,
  input  logic [NAME_W-1:0]     chk_name_i,
  input  logic [31:0]           chk_exp_i,
  input  logic                  clr_i,
  input  logic [NUM_CS-1:0]     cs_exp_i,
  input  logic                  fin_i,
  input  int                    timeouts_i,
  input  logic [31:0]           wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  busy_i,
  input  logic                  sclk_i,
  input  logic                  mosi_i,
  input  logic [NUM_CS-1:0]     cs_n_i,
  input  logic [GPIO_WIDTH-1:0] pad_i,
  output int                    fail_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] K_BUS  = 2'd0;
  localparam logic [1:0] K_PAD  = 2'd1;
  localparam logic [1:0] K_PINS = 2'd2;
  localparam logic [1:0] K_SPI  = 2'd3;

  logic [31:0] rd_q;
  logic        sclk_q;
  int          edges;
  int          cs_errs;
  int          n_tests;
  int          n_fail;

  function automatic string unpack_name(input logic [NAME_W-1:0] v);
    string s;
    byte   c;
    s = "";
    for (int i = NAME_W/8 - 1; i >= 0; i--) begin
      c = v[i*8 +: 8];
      if (c != 0) s = {s, string'(c)};
    end
    return s;
  endfunction

  task automatic judge();
    string       nm;
    logic [31:0] act;
    bit          ok;
    nm  = unpack_name(chk_name_i);
    ok  = 1'b1;
    act = '0;
    n_tests++;
    case (chk_kind_i)
      K_BUS:  act = rd_q;
      K_PAD:  act = 32'(pad_i);
      K_PINS: act = 32'({mosi_i, sclk_i, cs_n_i});
      default: act = 32'(edges);
    endcase
    if (act !== chk_exp_i) begin
      ok = 1'b0;
      $display("ERR %s expected 0x%08h actual 0x%08h", nm, chk_exp_i, act);
    end
    if (chk_kind_i == K_SPI && cs_errs != 0) begin
      ok = 1'b0;
      $display("FAIL %s: chip select did not match the CS register in %0d cycles",
               nm, cs_errs);
    end
    if (chk_kind_i == K_SPI && cs_n_i !== '1) begin
      ok = 1'b0;
      $display("FAIL %s: chip select was not released after the transfer", nm);
    end
    if (ok) begin
      $display("PASS %s value 0x%08h", nm, act);
    end else begin
      n_fail++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      sclk_q  <= 1'b0;
      edges   <= 0;
      cs_errs <= 0;
    end else begin
      sclk_q <= sclk_i;
      if (wb_ack_i) rd_q <= wb_dat_i;
      if (clr_i) begin
        edges   <= 0;
        cs_errs <= 0;
      end else begin
        if (sclk_i && !sclk_q) edges <= edges + 1;
        if (busy_i && (cs_n_i !== ~cs_exp_i)) cs_errs <= cs_errs + 1;
      end
      if (chk_stb_i) judge();
      if (fin_i) begin
        $display("Tests %0d, passed %0d, failed %0d, timeouts %0d",
                 n_tests, n_tests - n_fail, n_fail, timeouts_i);
      end
    end
  end

  initial begin
    n_tests = 0;
    n_fail  = 0;
  end

  assign fail_cnt_o = n_fail;

endmodule

//--- logic/periph_top.sv
/* GPIO and SPI peripheral top */

module periph_top #(
  parameter int GPIO_WIDTH = 8,
  parameter int NUM_CS     = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  periph_regs_pkg::wb_addr_t wb_adr_i,
  input  periph_regs_pkg::wb_data_t wb_dat_i,
  output periph_regs_pkg::wb_data_t wb_dat_o,
  output logic                      wb_ack_o,

  inout  wire  [GPIO_WIDTH-1:0]     gpio_io,

  output logic                      spi_sclk_o,
  output logic                      spi_mosi_o,
  input  logic                      spi_miso_i,
  output logic [NUM_CS-1:0]         spi_cs_n_o
);

  import spi_pkg::*;

  // GPIO path between bank and pads
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_dir;
  logic [GPIO_WIDTH-1:0] gpio_in;

  // SPI control and status
  logic                  spi_start;
  spi_word_t             spi_tx_word;
  spi_div_t              spi_div;
  logic [NUM_CS-1:0]     spi_cs_sel;
  logic                  spi_busy;
  logic                  spi_done;
  spi_word_t             spi_rx_word;

  wb_reg_bank #(
    .GPIO_WIDTH (GPIO_WIDTH),
    .NUM_CS     (NUM_CS)
  ) i_reg_bank (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .gpio_in_i     (gpio_in),
    .gpio_out_o    (gpio_out),
    .gpio_dir_o    (gpio_dir),
    .spi_start_o   (spi_start),
    .spi_tx_word_o (spi_tx_word),
    .spi_div_o     (spi_div),
    .spi_cs_sel_o  (spi_cs_sel),
    .spi_busy_i    (spi_busy),
    .spi_done_i    (spi_done),
    .spi_rx_word_i (spi_rx_word)
  );

  periph_iobuf #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_gpio_iobuf (
    .dir_i  (gpio_dir),
    .dout_i (gpio_out),
    .din_o  (gpio_in),
    .pad_io (gpio_io)
  );

  spi_sequencer #(
    .NUM_CS (NUM_CS)
  ) i_spi_seq (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .spi_start_i   (spi_start),
    .spi_div_i     (spi_div),
    .spi_cs_sel_i  (spi_cs_sel),
    .spi_tx_word_i (spi_tx_word),
    .spi_busy_o    (spi_busy),
    .spi_done_o    (spi_done),
    .spi_rx_word_o (spi_rx_word),
    .spi_sclk_o    (spi_sclk_o),
    .spi_mosi_o    (spi_mosi_o),
    .spi_miso_i    (spi_miso_i),
    .spi_cs_n_o    (spi_cs_n_o)
  );

endmodule

//--- logic/spi_sequencer.sv
/* SPI transfer sequencer */

module spi_sequencer #(
  parameter int NUM_CS = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                spi_start_i,
  input  spi_pkg::spi_div_t   spi_div_i,
  input  logic [NUM_CS-1:0]   spi_cs_sel_i,
  input  spi_pkg::spi_word_t  spi_tx_word_i,

  output logic                spi_busy_o,
  output logic                spi_done_o,
  output spi_pkg::spi_word_t  spi_rx_word_o,

  output logic                spi_sclk_o,
  output logic                spi_mosi_o,
  input  logic                spi_miso_i,
  output logic [NUM_CS-1:0]   spi_cs_n_o
);

  import spi_pkg::*;

  spi_state_e state_q;
  spi_state_e state_d;
  logic       sclk_q;
  logic       tmr_run;
  logic       half_tick;
  logic       last_bit;
  logic       shift_load;
  logic       shift_sample;
  logic       shift_out;

  // ************************************************************************
  // State machine

  // SHIFT ends on the falling edge that follows the eighth bit
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       if (spi_start_i) state_d = ASSERT_CS;
      ASSERT_CS:  state_d = SHIFT;
      SHIFT:      if (half_tick && sclk_q && last_bit) state_d = RELEASE_CS;
      RELEASE_CS: state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      sclk_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (half_tick) begin
        sclk_q <= ~sclk_q;
      end
    end
  end

  // Mode 0: sample on the rising edge, shift on the falling edge
  assign tmr_run      = (state_q == SHIFT);
  assign shift_load   = (state_q == ASSERT_CS);
  assign shift_sample = half_tick && !sclk_q;
  assign shift_out    = half_tick && sclk_q;

  assign spi_busy_o = (state_q != IDLE);
  assign spi_done_o = (state_q == RELEASE_CS);
  assign spi_sclk_o = sclk_q;
  assign spi_cs_n_o = (state_q != IDLE) ? ~spi_cs_sel_i : '1;

  spi_clk_timer i_clk_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .run_i       (tmr_run),
    .div_i       (spi_div_i),
    .bit_adv_i   (shift_out),
    .half_tick_o (half_tick),
    .last_bit_o  (last_bit)
  );

  spi_shift_reg i_shift_reg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_i      (shift_load),
    .load_word_i (spi_tx_word_i),
    .sample_i    (shift_sample),
    .shift_i     (shift_out),
    .miso_i      (spi_miso_i),
    .mosi_o      (spi_mosi_o),
    .rx_word_o   (spi_rx_word_o)
  );

endmodule

//--- logic/spi_shift_reg.sv
/* SPI shift register */

module spi_shift_reg (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               load_i,
  input  spi_pkg::spi_word_t load_word_i,
  input  logic               sample_i,
  input  logic               shift_i,
  input  logic               miso_i,
  output logic               mosi_o,
  output spi_pkg::spi_word_t rx_word_o
);

  import spi_pkg::*;

  spi_word_t tx_q;
  spi_word_t rx_q;

  // Outgoing word, MSB on the line, zeros fill from the bottom
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_q <= '0;
    end else if (load_i) begin
      tx_q <= load_word_i;
    end else if (shift_i) begin
      tx_q <= {tx_q[SPI_WORD_W-2:0], 1'b0};
    end
  end

  // Incoming bits enter at the LSB and end up MSB first
  always_ff @(posedge clk_i) begin
    if (sample_i) begin
      rx_q <= {rx_q[SPI_WORD_W-2:0], miso_i};
    end
  end

  assign mosi_o    = tx_q[SPI_WORD_W-1];
  assign rx_word_o = rx_q;

endmodule

//--- logic/spi_clk_timer.sv
/* SPI clock timer */

module spi_clk_timer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              run_i,
  input  spi_pkg::spi_div_t div_i,
  input  logic              bit_adv_i,
  output logic              half_tick_o,
  output logic              last_bit_o
);

  import spi_pkg::*;

  spi_div_t    cnt_q;
  spi_bitcnt_t bit_q;

  // Held at the divider value while stopped, so the first tick after
  // start comes div_i+1 cycles later
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!run_i || (cnt_q == '0)) begin
      cnt_q <= div_i;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign half_tick_o = run_i && (cnt_q == '0);

  // Bits completed in this transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !run_i) begin
      bit_q <= '0;
    end else if (bit_adv_i) begin
      bit_q <= bit_q + 1'b1;
    end
  end

  assign last_bit_o = (bit_q == '1);

endmodule

//--- logic/wb_reg_bank.sv
/* Wishbone register bank */

module wb_reg_bank #(
  parameter int GPIO_WIDTH = 8,
  parameter int NUM_CS     = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  periph_regs_pkg::wb_addr_t   wb_adr_i,
  input  periph_regs_pkg::wb_data_t   wb_dat_i,
  output periph_regs_pkg::wb_data_t   wb_dat_o,
  output logic                        wb_ack_o,

  input  logic [GPIO_WIDTH-1:0]       gpio_in_i,
  output logic [GPIO_WIDTH-1:0]       gpio_out_o,
  output logic [GPIO_WIDTH-1:0]       gpio_dir_o,

  output logic                        spi_start_o,
  output spi_pkg::spi_word_t          spi_tx_word_o,
  output spi_pkg::spi_div_t           spi_div_o,
  output logic [NUM_CS-1:0]           spi_cs_sel_o,

  input  logic                        spi_busy_i,
  input  logic                        spi_done_i,
  input  spi_pkg::spi_word_t          spi_rx_word_i
);

  import periph_regs_pkg::*;
  import spi_pkg::*;

  logic                  ack_q;
  wb_data_t              dat_q;
  wb_data_t              rd_data;
  logic                  req;
  logic                  wr_req;
  logic                  rd_req;

  logic [GPIO_WIDTH-1:0] gpio_out_q;
  logic [GPIO_WIDTH-1:0] gpio_dir_q;
  logic [GPIO_WIDTH-1:0] gpio_in_q;
  spi_div_t              div_q;
  logic [NUM_CS-1:0]     cs_q;
  spi_word_t             tx_q;
  spi_word_t             rx_q;
  logic                  start_q;

  // ************************************************************************
  // Bus handshake

  // A request is seen only in the cycle before ack, so ack lasts one cycle
  assign req    = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr_req = req && wb_we_i;
  assign rd_req = req && !wb_we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      dat_q <= RD_UNMAPPED;
    end else begin
      ack_q <= req;
      if (rd_req) begin
        dat_q <= rd_data;
      end
    end
  end

  // ************************************************************************
  // Writable registers and the start pulse

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= RST_GPIO_OUT[GPIO_WIDTH-1:0];
      gpio_dir_q <= RST_GPIO_DIR[GPIO_WIDTH-1:0];
      div_q      <= spi_div_t'(RST_SPI_DIV);
      cs_q       <= RST_SPI_CS[NUM_CS-1:0];
      tx_q       <= spi_word_t'(RST_SPI_DATA);
      rx_q       <= spi_word_t'(RST_SPI_DATA);
      start_q    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (wr_req) begin
        case (wb_adr_i)
          REG_GPIO_OUT: gpio_out_q <= wb_dat_i[GPIO_WIDTH-1:0];
          REG_GPIO_DIR: gpio_dir_q <= wb_dat_i[GPIO_WIDTH-1:0];
          REG_SPI_DIV:  div_q      <= wb_dat_i[SPI_DIV_W-1:0];
          REG_SPI_CS:   cs_q       <= wb_dat_i[NUM_CS-1:0];
          REG_SPI_DATA: begin
            // A write during a transfer is acknowledged and dropped
            if (!spi_busy_i) begin
              tx_q    <= wb_dat_i[SPI_WORD_W-1:0];
              start_q <= 1'b1;
            end
          end
          default: ;
        endcase
      end
      if (spi_done_i) begin
        rx_q <= spi_rx_word_i;
      end
    end
  end

  // Pads are sampled every cycle with one register of delay
  always_ff @(posedge clk_i) begin
    gpio_in_q <= gpio_in_i;
  end

  // ************************************************************************
  // Read mux

  always_comb begin
    rd_data = RD_UNMAPPED;
    case (wb_adr_i)
      REG_GPIO_OUT: rd_data = wb_data_t'(gpio_out_q);
      REG_GPIO_DIR: rd_data = wb_data_t'(gpio_dir_q);
      REG_GPIO_IN:  rd_data = wb_data_t'(gpio_in_q);
      REG_SPI_DIV:  rd_data = wb_data_t'(div_q);
      REG_SPI_CS:   rd_data = wb_data_t'(cs_q);
      REG_SPI_DATA: rd_data = wb_data_t'(rx_q);
      REG_STATUS:   rd_data[STATUS_BUSY_BIT] = spi_busy_i;
      default:      rd_data = RD_UNMAPPED;
    endcase
  end

  assign wb_ack_o      = ack_q;
  assign wb_dat_o      = dat_q;
  assign gpio_out_o    = gpio_out_q;
  assign gpio_dir_o    = gpio_dir_q;
  assign spi_start_o   = start_q;
  assign spi_tx_word_o = tx_q;
  assign spi_div_o     = div_q;
  assign spi_cs_sel_o  = cs_q;

endmodule

//--- logic/periph_iobuf.sv
/* Tristate pad buffer */

module periph_iobuf #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic [GPIO_WIDTH-1:0] dir_i,
  input  logic [GPIO_WIDTH-1:0] dout_i,
  output logic [GPIO_WIDTH-1:0] din_o,
  inout  wire  [GPIO_WIDTH-1:0] pad_io
);

  // One buffer per pad, enabled by its direction bit
  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pad
    assign pad_io[i] = dir_i[i] ? dout_i[i] : 1'bz;
  end

  // The input side sees the resolved pad, so a driven pin reads its own value
  assign din_o = pad_io;

endmodule

//--- logic/spi_pkg.sv
/* SPI master types */

package spi_pkg;

  // Word size moved per transfer, MSB first
  localparam int SPI_WORD_W = 8;
  localparam int SPI_DIV_W  = 8;
  localparam int SPI_BITCNT_W = $clog2(SPI_WORD_W);

  typedef logic [SPI_WORD_W-1:0]   spi_word_t;

  // Half period of SCLK is this count plus one system clock cycles
  typedef logic [SPI_DIV_W-1:0]    spi_div_t;

  typedef logic [SPI_BITCNT_W-1:0] spi_bitcnt_t;

  // Transfer sequencer states
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    ASSERT_CS  = 2'd1,
    SHIFT      = 2'd2,
    RELEASE_CS = 2'd3
  } spi_state_e;

endpackage

//--- logic/periph_regs_pkg.sv
/* Peripheral register map */

package periph_regs_pkg;

  // Bus widths
  localparam int WB_ADDR_W = 3;
  localparam int WB_DATA_W = 32;

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  // ************************************************************************
  // Word addresses
  localparam wb_addr_t REG_GPIO_OUT = 3'd0;
  localparam wb_addr_t REG_GPIO_DIR = 3'd1;
  localparam wb_addr_t REG_GPIO_IN  = 3'd2;
  localparam wb_addr_t REG_SPI_DIV  = 3'd3;
  localparam wb_addr_t REG_SPI_CS   = 3'd4;
  localparam wb_addr_t REG_SPI_DATA = 3'd5;
  localparam wb_addr_t REG_STATUS   = 3'd6;

  // Busy flag position in the status word
  localparam int STATUS_BUSY_BIT = 0;

  // ************************************************************************
  // Reset values, and the value returned for an unmapped address
  localparam wb_data_t RST_GPIO_OUT = '0;
  localparam wb_data_t RST_GPIO_DIR = '0;
  localparam wb_data_t RST_SPI_DIV  = 32'd1;
  localparam wb_data_t RST_SPI_CS   = '0;
  localparam wb_data_t RST_SPI_DATA = '0;
  localparam wb_data_t RD_UNMAPPED  = '0;

endpackage
